/* Bender.yml */
package:
  name: sap4

sources:
  - files:
      - src/sapPkg.sv
      - src/programLoader.sv
      - src/programMemory.sv
      - src/controlSequencer.sv
      - src/datapath.sv
      - src/outputPort.sv
      - src/sapTop.sv
  - target: test
    files:
      - dv/sapTb.sv

/* dv/sapTb.sv */
// testbench for sapTop with clock, program table, handshake drivers, LFSR, checker and watchdog
`timescale 1ns/1ps

module sapTb
  import sapPkg::*;
();

  localparam int periodNs       = 40;
  localparam int numRows        = 8;
  localparam int rowBoundCycles = 600; // generous per-row budget incl. worst ack delays

  typedef struct {
    nibbleT x;
    nibbleT y;
    nibbleT expSum;  // y + x modulo 16
    nibbleT expDiff; // y - x modulo 16
    nibbleT expAnd;  // y & x
  } rowT;

  // operands x and y with expected results, edge cases first
  rowT rows [numRows] = '{
    '{4'h0, 4'h0, 4'h0, 4'h0, 4'h0},
    '{4'h1, 4'hF, 4'h0, 4'hE, 4'h1},
    '{4'h9, 4'h3, 4'hC, 4'hA, 4'h1},
    '{4'h3, 4'h9, 4'hC, 4'h6, 4'h1},
    '{4'hF, 4'hF, 4'hE, 4'h0, 4'hF},
    '{4'h5, 4'hA, 4'hF, 4'h5, 4'h0},
    '{4'hC, 4'h7, 4'h3, 4'hB, 4'h4},
    '{4'h6, 4'h6, 4'hC, 4'h0, 4'h6}
  };

  // main program at addresses 0 to 12
  wordT mainProg [13] = '{
    {opLoad, 4'd14}, {opXchg, 4'd0}, {opLoad, 4'd15}, {opAdd, 4'd0},
    {opOut, 4'd0}, {opLoad, 4'd15}, {opSub, 4'd0}, {opOut, 4'd0},
    {opLoad, 4'd15}, {opAnd, 4'd0}, {opStore, 4'd13}, {opXchg, 4'd0},
    {opHalt, 4'd0}
  };

  logic   clk;
  logic   reset;
  logic   loadReq;
  addrT   loadAddr;
  wordT   loadData;
  logic   loadAck;
  logic   start;
  logic   halted;
  logic   outReq;
  nibbleT outData;
  logic   outAck;

  logic [15:0] lfsr = 16'd31725;
  int          ackRises = 0;
  int          reqCount = 0;
  logic        prevAck = 1'b0;
  nibbleT      expQ [$];

  sapTop u_sapTop (
    .clk, .reset, .loadReq, .loadAddr, .loadData, .loadAck,
    .start, .halted, .outReq, .outData, .outAck
  );

  initial
    clk = 1'b0;

  always #(periodNs / 2) clk = ~clk;

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // 16-bit fibonacci with taps 16 14 13 11
  function automatic int takeBits(input int n);
    int   value;
    logic fb;
    value = 0;
    for (int k = 0; k < n; k++)
    begin
      fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr  = {lfsr[14:0], fb};
      value = (value << 1) | fb;
    end
    return value;
  endfunction

  // one four-phase write where ack only appears once halted
  task automatic loadWord(input addrT addr, input wordT data);
    int   waited;
    logic wasHalted;
    @(negedge clk);
    wasHalted = halted;
    loadAddr  = addr;
    loadData  = data;
    loadReq   = 1'b1;
    reqCount++;
    waited = 1;
    @(negedge clk);
    while (!loadAck)
    begin
      waited++;
      @(negedge clk);
    end
    checkValue(halted, 1'b1, "loadAck while running");
    if (wasHalted)
      checkValue(waited, 1, "loadAck latency while halted");
    @(negedge clk);
    checkValue(loadAck, 1'b1, "loadAck fell while loadReq high");
    loadReq = 1'b0;
    @(negedge clk);
    checkValue(loadAck, 1'b0, "loadAck still high after loadReq fell");
  endtask

  task automatic pulseStart();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    checkValue(halted, 1'b0, "halted after start");
  endtask

  // receive outputs in order until the machine halts and stays quiet
  task automatic collectOutputs();
    nibbleT held;
    int     delay;
    int     quiet;
    quiet = 0;
    while (quiet < 4)
    begin
      @(negedge clk);
      if (outReq)
      begin
        checkValue(quiet, 0, "outReq raised after halted");
        checkValue(expQ.size() > 0, 1'b1, "output beyond the expected sequence");
        held = outData;
        checkValue(held, expQ.pop_front(), "output value");
        delay = takeBits(4);
        repeat (delay)
        begin
          @(negedge clk);
          checkValue(outReq, 1'b1, "outReq dropped before outAck");
          checkValue(outData, held, "outData changed while outReq high");
        end
        outAck = 1'b1;
        @(negedge clk);
        while (outReq)
        begin
          checkValue(outData, held, "outData changed before outReq fell");
          @(negedge clk);
        end
        outAck = 1'b0;
      end
      else if (halted)
        quiet++;
    end
    checkValue(expQ.size(), 0, "outputs missing at halt");
  endtask

  // counts rising edges of loadAck
  always @(negedge clk)
  begin
    if (reset && loadAck && !prevAck)
      ackRises++;
    prevAck = loadAck;
  end

  initial
  begin
    nibbleT x;
    nibbleT y;
    reset    = 1'b0;
    loadReq  = 1'b0;
    loadAddr = '0;
    loadData = '0;
    start    = 1'b0;
    outAck   = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    checkValue(halted, 1'b1, "halted after reset");
    checkValue(loadAck, 1'b0, "loadAck after reset");
    checkValue(outReq, 1'b0, "outReq after reset");

    for (int n = 0; n < numRows; n++)
    begin
      x = rows[n].x;
      y = rows[n].y;
      for (int a = 0; a < 13; a++)
        loadWord(addrT'(a), mainProg[a]);
      loadWord(4'd14, {4'h0, x});
      loadWord(4'd15, {4'h0, y});

      expQ = {};
      expQ.push_back(rows[n].expSum);
      expQ.push_back(rows[n].expDiff);
      pulseStart();
      fork
        collectOutputs();
        begin
          repeat (3) @(negedge clk);
          loadWord(4'd0, {opOut, 4'd0}); // held off until halt
        end
      join

      // follow-up run outputs A from the last exchange and then the stored word 13
      loadWord(4'd1, {opLoad, 4'd13});
      loadWord(4'd2, {opOut, 4'd0});
      loadWord(4'd3, {opHalt, 4'd0});
      expQ = {};
      expQ.push_back(x);
      expQ.push_back(rows[n].expAnd);
      pulseStart();
      collectOutputs();
    end

    repeat (2) @(negedge clk);
    checkValue(ackRises, reqCount, "loadAck count against requests");
    $display("RESULT: PASS");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (numRows * rowBoundCycles + 10) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles",
             numRows * rowBoundCycles + 10);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

/* sources.f */
src/sapPkg.sv
src/programLoader.sv
src/programMemory.sv
src/controlSequencer.sv
src/datapath.sv
src/outputPort.sv
src/sapTop.sv
dv/sapTb.sv

/* src/controlSequencer.sv */
// six-step control ring, halt/run flag and per-step strobe decode
`timescale 1ns/1ps

module controlSequencer
  import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  opcodeT opcode,
  input  logic   busy,
  output logic   halted,
  output logic   pcToMar,
  output logic   pcInc,
  output logic   irLoad,
  output logic   irToMar,
  output logic   aLoadMem,
  output logic   aLoadAlu,
  output logic   aLoadB,
  output logic   tmpLoadA,
  output logic   bLoadTmp,
  output logic   aluLatch,
  output logic   storeWe,
  output logic   outLoad
);

  stepT step;
  logic stallOut;
  logic haltNow;

  assign stallOut = (step == stepEx1) && (opcode == opOut) && busy; // wait for output port
  assign haltNow  = (step == stepEx1) && (opcode == opHalt);

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      step   <= stepIdle;
      halted <= 1'b1;
    end
    else if (halted)
    begin
      if (start)
      begin
        halted <= 1'b0;
        step   <= stepAddr;
      end
    end
    else if (haltNow)
    begin
      halted <= 1'b1;
      step   <= stepIdle;
    end
    else if (!stallOut)
      step <= {step[4:0], step[5]}; // ex3 wraps back to addr
  end

  always_comb
  begin
    pcToMar  = 1'b0;
    pcInc    = 1'b0;
    irLoad   = 1'b0;
    irToMar  = 1'b0;
    aLoadMem = 1'b0;
    aLoadAlu = 1'b0;
    aLoadB   = 1'b0;
    tmpLoadA = 1'b0;
    bLoadTmp = 1'b0;
    aluLatch = 1'b0;
    storeWe  = 1'b0;
    outLoad  = 1'b0;
    case (step)
      stepAddr:  pcToMar = 1'b1;
      stepInc:   pcInc   = 1'b1;
      stepFetch: irLoad  = 1'b1;
      stepEx1:
        case (opcode)
          opLoad, opStore:     irToMar  = 1'b1;
          opXchg:              tmpLoadA = 1'b1; // tmp <= a
          opAdd, opSub, opAnd: aluLatch = 1'b1;
          opOut:               outLoad  = !busy;
          default:             ;
        endcase
      stepEx2:
        case (opcode)
          opLoad:              aLoadMem = 1'b1;
          opXchg:              aLoadB   = 1'b1; // a <= b
          opAdd, opSub, opAnd: aLoadAlu = 1'b1;
          opStore:             storeWe  = 1'b1;
          default:             ;
        endcase
      stepEx3:
        if (opcode == opXchg)
          bLoadTmp = 1'b1; // b <= tmp
      default: ;
    endcase
  end

  // ring stays one-hot while running and empty while halted
  ringShape: assert property (@(posedge clk) disable iff (!reset)
    halted ? (step == stepIdle) : $onehot(step));

  oneALoad: assert property (@(posedge clk) disable iff (!reset)
    $onehot0({aLoadMem, aLoadAlu, aLoadB}));

endmodule

/* src/datapath.sv */
// program counter, address and instruction registers, A, B, temp register and ALU
`timescale 1ns/1ps

module datapath
  import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   start,
  input  logic   pcToMar,
  input  logic   pcInc,
  input  logic   irLoad,
  input  logic   irToMar,
  input  logic   aLoadMem,
  input  logic   aLoadAlu,
  input  logic   aLoadB,
  input  logic   tmpLoadA,
  input  logic   bLoadTmp,
  input  logic   aluLatch,
  input  wordT   rdWord,
  output opcodeT opcode,
  output addrT   marAddr,
  output nibbleT aValue
);

  addrT   pc;
  addrT   mar;
  wordT   ir;
  nibbleT regA;
  nibbleT regB;
  nibbleT regTmp;
  nibbleT aluResult;
  nibbleT aluOut;     // latched result, taken by A one step later

  assign opcode  = opcodeT'(ir[7:4]);
  assign marAddr = mar;
  assign aValue  = regA;

  // start only arrives while halted, so it never races an increment
  always_ff @(posedge clk)
  begin
    if (!reset)
      pc <= '0;
    else if (start)
      pc <= '0;
    else if (pcInc)
      pc <= pc + addrT'(1); // wraps 15 -> 0
  end

  always_ff @(posedge clk)
  begin
    if (pcToMar)
      mar <= pc;
    else if (irToMar)
      mar <= ir[addrW-1:0]; // operand field is the address
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      ir <= '0;
    else if (irLoad)
      ir <= rdWord;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      regA   <= '0;
      regB   <= '0;
      regTmp <= '0;
    end
    else
    begin
      if (aLoadMem)
        regA <= rdWord[dataW-1:0];
      else if (aLoadAlu)
        regA <= aluOut;
      else if (aLoadB)
        regA <= regB;
      if (tmpLoadA)
        regTmp <= regA;
      if (bLoadTmp)
        regB <= regTmp;
    end
  end

  // results are modulo 16
  always_comb
  begin
    case (opcode)
      opAdd:   aluResult = regA + regB;
      opSub:   aluResult = regA - regB;
      opAnd:   aluResult = regA & regB;
      default: aluResult = regA;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (aluLatch)
      aluOut <= aluResult;
  end

endmodule

/* src/outputPort.sv */
// four-phase req/ack sender for output values with busy back to the sequencer
`timescale 1ns/1ps

module outputPort
  import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   outLoad,
  input  nibbleT aValue,
  input  logic   outAck,
  output logic   busy,
  output logic   outReq,
  output nibbleT outData
);

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      outReq <= 1'b0;
      busy   <= 1'b0;
    end
    else if (outLoad)
    begin
      outReq <= 1'b1;
      busy   <= 1'b1;
    end
    else if (outReq && outAck)
      outReq <= 1'b0; // ack seen, drop request
    else if (busy && !outReq && !outAck)
      busy <= 1'b0; // handshake closed
  end

  // held value, changes only when a new output is loaded
  always_ff @(posedge clk)
  begin
    if (outLoad)
      outData <= aValue;
  end

  dataHeld: assert property (@(posedge clk) disable iff (!reset)
    (outReq && !outAck) |=> $stable(outData));

endmodule

/* src/programLoader.sv */
// four-phase req/ack receiver that writes program words into memory while halted
`timescale 1ns/1ps

module programLoader
  import sapPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic loadReq,
  input  addrT loadAddr,
  input  wordT loadData,
  input  logic halted,
  output logic loadAck,
  output logic memWe,
  output addrT memAddr,
  output wordT memData
);

  typedef enum logic {
    ldIdle,
    ldAck
  } ldStateT;

  ldStateT state;

  // one write per request, only on the idle-to-ack transition
  assign memWe   = (state == ldIdle) && loadReq && halted;
  assign memAddr = loadAddr;
  assign memData = loadData;
  assign loadAck = (state == ldAck);

  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= ldIdle;
    else
    begin
      case (state)
        ldIdle:
          if (loadReq && halted) // held off while the core runs
            state <= ldAck;
        ldAck:
          if (!loadReq)
            state <= ldIdle;
        default:
          state <= ldIdle;
      endcase
    end
  end

  // ack never rises without a request pending
  ackNeedsReq: assert property (@(posedge clk) disable iff (!reset)
    (!loadReq && !loadAck) |=> !loadAck);

endmodule

/* src/programMemory.sv */
// 16-word program and data memory with combinational read and shared write port
`timescale 1ns/1ps

module programMemory
  import sapPkg::*;
(
  input  logic   clk,
  input  logic   halted,
  input  logic   memWe,
  input  addrT   memAddr,
  input  wordT   memData,
  input  logic   storeWe,
  input  addrT   marAddr,
  input  nibbleT aValue,
  output wordT   rdWord
);

  wordT mem [memDepth];

  assign rdWord = mem[marAddr];

  // loader owns the write port while halted, the core while running
  always_ff @(posedge clk)
  begin
    if (halted)
    begin
      if (memWe)
        mem[memAddr] <= memData;
    end
    else if (storeWe)
      mem[marAddr] <= wordT'(aValue); // upper nibble zero
  end

  // sequencer must never issue a store once the machine has halted
  noStoreHalted: assert property (@(posedge clk) storeWe |-> !halted);

endmodule

/* src/sapPkg.sv */
// widths, data types, opcode enum and step ring encoding for the accumulator machine
package sapPkg;

  localparam int dataW    = 4;
  localparam int addrW    = 4;
  localparam int memDepth = 16;

  typedef logic [dataW-1:0]   nibbleT;
  typedef logic [addrW-1:0]   addrT;
  // opcode in upper nibble, operand or address in lower nibble
  typedef logic [2*dataW-1:0] wordT;

  typedef enum logic [3:0] {
    opAdd   = 4'b0001,
    opSub   = 4'b0010,
    opXchg  = 4'b0011,
    opStore = 4'b0110,
    opLoad  = 4'b0111,
    opAnd   = 4'b1000,
    opOut   = 4'b1010,
    opHalt  = 4'b1111
  } opcodeT;

  // one-hot control ring, all zero while halted
  typedef logic [5:0] stepT;

  localparam stepT stepIdle  = 6'b000000;
  localparam stepT stepAddr  = 6'b000001; // pc into mar
  localparam stepT stepInc   = 6'b000010; // pc + 1
  localparam stepT stepFetch = 6'b000100; // memory word into ir
  localparam stepT stepEx1   = 6'b001000;
  localparam stepT stepEx2   = 6'b010000;
  localparam stepT stepEx3   = 6'b100000;

endpackage

/* src/sapTop.sv */
// top level connecting loader, memory, sequencer, datapath and output port
`timescale 1ns/1ps

module sapTop
  import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   loadReq,
  input  addrT   loadAddr,
  input  wordT   loadData,
  output logic   loadAck,
  input  logic   start,
  output logic   halted,
  output logic   outReq,
  output nibbleT outData,
  input  logic   outAck
);

  logic   memWe;
  addrT   memAddr;
  wordT   memData;
  wordT   rdWord;
  addrT   marAddr;
  nibbleT aValue;
  opcodeT opcode;
  logic   busy;
  logic   pcToMar, pcInc, irLoad, irToMar;
  logic   aLoadMem, aLoadAlu, aLoadB;
  logic   tmpLoadA, bLoadTmp, aluLatch;
  logic   storeWe, outLoad;

  programLoader u_programLoader (
    .clk, .reset, .loadReq, .loadAddr, .loadData, .halted,
    .loadAck, .memWe, .memAddr, .memData
  );

  programMemory u_programMemory (
    .clk, .halted, .memWe, .memAddr, .memData,
    .storeWe, .marAddr, .aValue, .rdWord
  );

  controlSequencer u_controlSequencer (
    .clk, .reset, .start, .opcode, .busy, .halted,
    .pcToMar, .pcInc, .irLoad, .irToMar,
    .aLoadMem, .aLoadAlu, .aLoadB,
    .tmpLoadA, .bLoadTmp, .aluLatch,
    .storeWe, .outLoad
  );

  datapath u_datapath (
    .clk, .reset, .start,
    .pcToMar, .pcInc, .irLoad, .irToMar,
    .aLoadMem, .aLoadAlu, .aLoadB,
    .tmpLoadA, .bLoadTmp, .aluLatch,
    .rdWord, .opcode, .marAddr, .aValue
  );

  outputPort u_outputPort (
    .clk, .reset, .outLoad, .aValue, .outAck,
    .busy, .outReq, .outData
  );

endmodule
